//--- ow_master.f
source/ow_pkg.sv
source/ow_bit_if.sv
source/ow_crc8.sv
source/ow_bit_engine.sv
source/ow_byte_ctrl.sv
source/ow_master.sv
tests/ow_slave_model.sv
tests/ow_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ow_master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ow_master_tb -f ow_master.f -o ow_master_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/ow_master_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/ow_master_tb.sv
module ow_master_tb import ow_pkg::*; ();

	logic clk;
	logic local_reset;
	logic ow_bus;
	logic ow_out;
	logic pull_dn;
	ow_byte_t bus_in;
	ow_byte_t bus_out;
	ow_cmd_t cmd;
	logic presence;
	logic error;
	logic done;
	logic crc8_enable;
	logic crc_valid;
	logic present;
	logic stuck;
	int seed;
	int errors;
	int tests_run;

	// open drain line, either side can pull it low
	assign ow_bus = ow_out & ~pull_dn;

	ow_master dut0
	(
		.clk(clk),
		.local_reset(local_reset),
		.ow_in(ow_bus),
		.ow_out(ow_out),
		.bus_in(bus_in),
		.bus_out(bus_out),
		.cmd(cmd),
		.presence(presence),
		.error(error),
		.done(done),
		.crc8_enable(crc8_enable),
		.crc_valid(crc_valid)
	);

	ow_slave_model slave0
	(
		.ow_bus(ow_bus),
		.present(present),
		.stuck(stuck),
		.pull_dn(pull_dn)
	);

	always #2 clk = ~clk;

	task automatic check_byte(input ow_byte_t got, input ow_byte_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		if (errors == start)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d errors", name, errors - start);
	endtask

	function automatic ow_byte_t rand_byte();
		return 8'($random(seed));
	endfunction

	// reflected Dallas CRC-8, one byte lsb first
	function automatic ow_byte_t crc8_ref(input ow_byte_t crc, input ow_byte_t data);
		ow_byte_t c;
		int i;
		c = crc;
		for (i = 0; i < 8; i++)
		begin
			if (c[0] ^ data[i])
				c = (c >> 1) ^ CRC8_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// bus_out must read zero for as long as done is low
	task automatic wait_done_level(input logic level);
		int cycles;
		int limit;
		cycles = 0;
		limit = (RESET_END_US + RECOVERY_US) * CLKS_PER_US + 64;
		while (done !== level && cycles < limit)
		begin
			if (done === 1'b0)
				check_byte(bus_out, 8'h00, "bus_out while busy");
			@(posedge clk);
			cycles++;
		end
		if (done !== level)
		begin
			$display("timeout: done did not go to %b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic run_cmd(input ow_cmd_t c, input ow_byte_t data);
		@(posedge clk);
		cmd <= c;
		bus_in <= data;
		wait_done_level(1'b0);
		wait_done_level(1'b1);
		cmd <= OW_CMD_NONE;
	endtask

	task automatic test_reset(input logic slave_present, input string name);
		int start;
		start = errors;
		@(posedge clk);
		present <= slave_present;
		run_cmd(OW_CMD_RESET, 8'h00);
		check_flag(presence, slave_present, "presence");
		check_flag(error, 1'b0, "error");
		report_test(name, start);
	endtask

	task automatic test_stuck_bus();
		int start;
		start = errors;
		@(posedge clk);
		present <= 1'b1;
		stuck <= 1'b1;
		run_cmd(OW_CMD_RESET, 8'h00);
		check_flag(error, 1'b1, "error with the line held low");
		check_flag(presence, 1'b1, "presence with the line held low");
		stuck <= 1'b0;
		run_cmd(OW_CMD_RESET, 8'h00);
		check_flag(error, 1'b0, "error after release");
		report_test("reset on a stuck line", start);
	endtask

	task automatic test_write();
		int start;
		int i;
		ow_byte_t data;
		start = errors;
		slave0.wr_log.delete();
		for (i = 0; i < 4; i++)
		begin
			data = rand_byte();
			run_cmd(OW_CMD_WRITE, data);
			if (slave0.wr_log.size() != i + 1)
			begin
				$display("slave logged %0d bytes after write %0d, expected %0d",
					slave0.wr_log.size(), i, i + 1);
				errors++;
			end
			else
				check_byte(slave0.wr_log[i], data, "written byte");
		end
		report_test("byte write", start);
	endtask

	task automatic test_read();
		int start;
		int i;
		ow_byte_t data [4];
		start = errors;
		for (i = 0; i < 4; i++)
		begin
			data[i] = rand_byte();
			slave0.rd_queue.push_back(data[i]);
		end
		for (i = 0; i < 4; i++)
		begin
			run_cmd(OW_CMD_READ, 8'h00);
			check_byte(bus_out, data[i], "read byte");
		end
		report_test("byte read", start);
	endtask

	task automatic test_crc();
		int start;
		int i;
		ow_byte_t frame [8];
		ow_byte_t crc_exp;
		start = errors;
		crc_exp = '0;
		for (i = 0; i < 7; i++)
		begin
			frame[i] = rand_byte();
			crc_exp = crc8_ref(crc_exp, frame[i]);
		end
		frame[7] = crc_exp;
		// short pulse, then enabled for the whole frame
		@(posedge clk);
		crc8_enable <= 1'b1;
		@(posedge clk);
		crc8_enable <= 1'b0;
		@(posedge clk);
		crc8_enable <= 1'b1;
		for (i = 0; i < 8; i++)
			slave0.rd_queue.push_back(frame[i]);
		for (i = 0; i < 8; i++)
		begin
			run_cmd(OW_CMD_READ, 8'h00);
			check_byte(bus_out, frame[i], "frame byte");
		end
		// last shift lands a cycle after done
		repeat (2) @(posedge clk);
		check_flag(crc_valid, 1'b1, "crc_valid after a good frame");
		slave0.rd_queue.push_back({frame[0][7:1], 1'b1});
		run_cmd(OW_CMD_READ, 8'h00);
		repeat (2) @(posedge clk);
		check_flag(crc_valid, 1'b0, "crc_valid after a corrupted byte");
		// a new rising edge of the enable clears the register
		@(posedge clk);
		crc8_enable <= 1'b0;
		@(posedge clk);
		crc8_enable <= 1'b1;
		repeat (2) @(posedge clk);
		check_flag(crc_valid, 1'b1, "crc_valid after the enable rises again");
		report_test("crc8", start);
	endtask

	initial
	begin
		clk = 1'b0;
		local_reset = 1'b1;
		cmd = OW_CMD_NONE;
		bus_in = '0;
		crc8_enable = 1'b0;
		present = 1'b1;
		stuck = 1'b0;
		seed = 82;
		errors = 0;
		tests_run = 0;
		repeat (2) @(posedge clk);
		local_reset <= 1'b0;
		@(posedge clk);
		check_flag(done, 1'b1, "done after reset");
		check_flag(ow_out, 1'b1, "ow_out after reset");
		check_flag(presence, 1'b0, "presence after reset");
		check_flag(error, 1'b0, "error after reset");
		check_byte(bus_out, 8'h00, "bus_out after reset");
		check_flag(crc_valid, 1'b1, "crc_valid after reset");
		test_reset(1'b1, "reset with presence");
		test_reset(1'b0, "reset without presence");
		test_stuck_bus();
		test_write();
		test_read();
		test_crc();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- tests/ow_slave_model.sv
module ow_slave_model import ow_pkg::*;
(
	input logic ow_bus,
	input logic present,
	input logic stuck,
	output logic pull_dn
);

	ow_byte_t rd_queue [$];
	ow_byte_t wr_log [$];
	ow_byte_t shift_in = '0;
	logic drive = 1'b0;
	logic [2:0] bit_idx = 3'd0;
	time t_fall;
	time low_time;

	// testbench clock period is 4 time units
	function automatic time us_to_time(input int n);
		return time'(n * 4 * CLKS_PER_US);
	endfunction

	assign pull_dn = drive | stuck;

	// every slot and every reset starts with a falling edge
	always @(negedge ow_bus)
	begin
		if (!stuck)
		begin
			t_fall = $time;
			// pending read data means the master is reading
			if (rd_queue.size() > 0 && !rd_queue[0][bit_idx])
			begin
				drive = 1'b1;
				#(us_to_time(30));
				drive = 1'b0;
			end
			if (ow_bus !== 1'b1)
				@(posedge ow_bus);
			low_time = $time - t_fall;
			if (low_time > us_to_time(400))
			begin
				bit_idx = 3'd0;
				if (present)
				begin
					#(us_to_time(15));
					drive = 1'b1;
					#(us_to_time(120));
					drive = 1'b0;
				end
			end
			else if (rd_queue.size() > 0)
			begin
				if (bit_idx == 3'd7)
					void'(rd_queue.pop_front());
				bit_idx = bit_idx + 3'd1;
			end
			else
			begin
				// short low pulse is a one, lsb first
				shift_in = {low_time < us_to_time(15), shift_in[7:1]};
				if (bit_idx == 3'd7)
					wr_log.push_back(shift_in);
				bit_idx = bit_idx + 3'd1;
			end
		end
	end

endmodule

//--- source/ow_master.sv
module ow_master import ow_pkg::*;
(
	input logic clk,
	input logic local_reset,
	input logic ow_in,
	output logic ow_out,
	input ow_byte_t bus_in,
	output ow_byte_t bus_out,
	input ow_cmd_t cmd,
	output logic presence,
	output logic error,
	output logic done,
	input logic crc8_enable,
	output logic crc_valid
);

	logic crc_bit;
	logic crc_shift;

	// byte controller to bit engine
	ow_bit_if bit_bus ();

	ow_byte_ctrl ctrl0
	(
		.clk(clk),
		.local_reset(local_reset),
		.cmd(cmd),
		.bus_in(bus_in),
		.bus_out(bus_out),
		.done(done),
		.crc_bit(crc_bit),
		.crc_shift(crc_shift),
		.bit_bus(bit_bus.ctrl)
	);

	ow_bit_engine engine0
	(
		.clk(clk),
		.local_reset(local_reset),
		.ow_in(ow_in),
		.ow_out(ow_out),
		.error(error),
		.bit_bus(bit_bus.engine)
	);

	// only bits read from the bus are checked
	ow_crc8 crc0
	(
		.clk(clk),
		.local_reset(local_reset),
		.enable(crc8_enable),
		.crc_bit(crc_bit),
		.crc_shift(crc_shift),
		.crc_valid(crc_valid)
	);

	assign presence = bit_bus.presence;

endmodule

//--- source/ow_byte_ctrl.sv
module ow_byte_ctrl import ow_pkg::*;
(
	input logic clk,
	input logic local_reset,
	input ow_cmd_t cmd,
	input ow_byte_t bus_in,
	output ow_byte_t bus_out,
	output logic done,
	output logic crc_bit,
	output logic crc_shift,
	ow_bit_if.ctrl bit_bus
);

	// state holds the byte command being run, none when idle
	ow_cmd_t state;
	logic cmd_q;
	logic accept;
	logic bit_done_q;
	logic pos_bit_done;
	logic last_bit;
	logic [2:0] bit_cnt;
	ow_byte_t data_buf;

	assign done = (state == OW_CMD_NONE);

	// rising edge of the command level, taken only when idle
	assign accept = (cmd != OW_CMD_NONE) && !cmd_q && done;

	// end of one slot or of the reset sequence
	assign pos_bit_done = bit_bus.bit_done && !bit_done_q;
	assign last_bit = (bit_cnt == 3'd7);

	// dropped for the cycle in which the engine reports the end,
	// otherwise the idle engine would take the same request twice
	assign bit_bus.bit_cmd = pos_bit_done ? OW_CMD_NONE : state;
	assign bit_bus.wr_bit = data_buf[0];

	assign bus_out = done ? data_buf : '0;

	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
		begin
			cmd_q <= 1'b0;
			bit_done_q <= 1'b1;
		end
		else
		begin
			cmd_q <= (cmd != OW_CMD_NONE);
			bit_done_q <= bit_bus.bit_done;
		end
	end

	// byte FSM
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
			state <= OW_CMD_NONE;
		else if (accept)
			state <= cmd;
		else if (pos_bit_done)
		begin
			if (state == OW_CMD_RESET || last_bit)
				state <= OW_CMD_NONE;
		end
	end

	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
			bit_cnt <= 3'd0;
		else if (accept)
			bit_cnt <= 3'd0;
		else if (pos_bit_done && (state == OW_CMD_READ || state == OW_CMD_WRITE))
			bit_cnt <= bit_cnt + 3'd1;
	end

	// lsb first on the wire in both directions
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
			data_buf <= '0;
		else if (accept && cmd == OW_CMD_WRITE)
			data_buf <= bus_in;
		else if (pos_bit_done)
		begin
			if (state == OW_CMD_READ)
				data_buf <= {bit_bus.rd_bit, data_buf[7:1]};
			else if (state == OW_CMD_WRITE)
				data_buf <= {data_buf[0], data_buf[7:1]};
		end
	end

	// every bit read goes to the CRC
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
		begin
			crc_shift <= 1'b0;
			crc_bit <= 1'b0;
		end
		else
		begin
			crc_shift <= pos_bit_done && (state == OW_CMD_READ);
			if (pos_bit_done && state == OW_CMD_READ)
				crc_bit <= bit_bus.rd_bit;
		end
	end

	idle_no_request: assert property (@(posedge clk) disable iff (local_reset)
		done |-> bit_bus.bit_cmd == OW_CMD_NONE);

	single_crc_shift: assert property (@(posedge clk) disable iff (local_reset)
		crc_shift |=> !crc_shift);

endmodule

//--- source/ow_bit_engine.sv
module ow_bit_engine import ow_pkg::*;
(
	input logic clk,
	input logic local_reset,
	input logic ow_in,
	output logic ow_out,
	output logic error,
	ow_bit_if.engine bit_bus
);

	logic busy;
	logic recovery;
	ow_cmd_t cur_cmd;
	logic wr_val;
	logic [7:0] us_cnt;
	logic us_tick;
	logic [9:0] slot_us;
	logic [9:0] slot_next;
	logic [9:0] low_us;
	logic [9:0] end_us;

	assign bit_bus.bit_done = ~busy;

	// microsecond prescaler
	assign us_tick = (us_cnt == 8'(CLKS_PER_US - 1));
	assign slot_next = slot_us + 10'd1;

	// how long the line stays low and when the active part ends
	always_comb
	begin
		if (cur_cmd == OW_CMD_RESET)
		begin
			low_us = 10'(RESET_LEN_US);
			end_us = 10'(RESET_END_US);
		end
		else
		begin
			// a zero is written by holding the line for the whole slot
			low_us = (cur_cmd == OW_CMD_WRITE && !wr_val) ? 10'(RW_SLOT_US) : 10'(RW_INIT_US);
			end_us = 10'(RW_SLOT_US);
		end
	end

	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
		begin
			us_cnt <= 8'd0;
			slot_us <= 10'd0;
		end
		else if (!busy)
		begin
			us_cnt <= 8'd0;
			slot_us <= 10'd0;
		end
		else if (us_tick)
		begin
			us_cnt <= 8'd0;
			// restart from zero for the recovery time
			if (!recovery && slot_next == end_us)
				slot_us <= 10'd0;
			else
				slot_us <= slot_next;
		end
		else
			us_cnt <= us_cnt + 8'd1;
	end

	// sequence control and line drive
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
		begin
			busy <= 1'b0;
			recovery <= 1'b0;
			cur_cmd <= OW_CMD_NONE;
			wr_val <= 1'b0;
			ow_out <= 1'b1;
		end
		else if (!busy)
		begin
			if (bit_bus.bit_cmd != OW_CMD_NONE)
			begin
				busy <= 1'b1;
				recovery <= 1'b0;
				cur_cmd <= bit_bus.bit_cmd;
				wr_val <= bit_bus.wr_bit;
				ow_out <= 1'b0;
			end
		end
		else if (us_tick)
		begin
			if (recovery)
			begin
				if (slot_next == 10'(RECOVERY_US))
				begin
					busy <= 1'b0;
					recovery <= 1'b0;
				end
			end
			else if (slot_next == end_us)
			begin
				recovery <= 1'b1;
				ow_out <= 1'b1;
			end
			else if (slot_next == low_us)
				ow_out <= 1'b1;
		end
	end

	// bus sampling points
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
		begin
			bit_bus.presence <= 1'b0;
			bit_bus.rd_bit <= 1'b0;
			error <= 1'b0;
		end
		else if (busy && !recovery && us_tick)
		begin
			if (cur_cmd == OW_CMD_RESET)
			begin
				if (slot_next == 10'(PRESENCE_SAMPLE_US))
					bit_bus.presence <= ~ow_in;
				// still low at the end means a shorted line
				if (slot_next == end_us)
					error <= ~ow_in;
			end
			else if (cur_cmd == OW_CMD_READ && slot_next == 10'(RW_SAMPLE_US))
				bit_bus.rd_bit <= ow_in;
		end
	end

	recovery_released: assert property (@(posedge clk) disable iff (local_reset)
		recovery |-> ow_out);

	init_low_time: assert property (@(posedge clk) disable iff (local_reset)
		$fell(bit_bus.bit_done) |-> !bit_bus.bit_done [*RW_INIT_US * CLKS_PER_US]);

endmodule

//--- source/ow_crc8.sv
module ow_crc8 import ow_pkg::*;
(
	input logic clk,
	input logic local_reset,
	input logic enable,
	input logic crc_bit,
	input logic crc_shift,
	output logic crc_valid
);

	ow_byte_t crc;
	logic enable_q;
	logic pos_enable;
	logic feedback;

	assign pos_enable = enable && !enable_q;
	assign feedback = crc[0] ^ crc_bit;

	// a byte stream followed by its own CRC leaves zero
	assign crc_valid = (crc == '0);

	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
			enable_q <= 1'b0;
		else
			enable_q <= enable;
	end

	// right shifting Dallas update
	always_ff @(posedge clk or posedge local_reset)
	begin
		if (local_reset)
			crc <= '0;
		else if (pos_enable)
			crc <= '0;
		else if (crc_shift && enable)
			crc <= (crc >> 1) ^ (feedback ? CRC8_POLY : '0);
	end

	clear_on_enable: assert property (@(posedge clk) disable iff (local_reset)
		$rose(enable) |=> crc == '0);

endmodule

//--- source/ow_bit_if.sv
interface ow_bit_if import ow_pkg::*; ();

	ow_cmd_t bit_cmd;
	logic wr_bit;
	logic rd_bit;
	// high while the engine is idle
	logic bit_done;
	logic presence;

	modport ctrl
	(
		output bit_cmd,
		output wr_bit,
		input rd_bit,
		input bit_done,
		input presence
	);

	modport engine
	(
		input bit_cmd,
		input wr_bit,
		output rd_bit,
		output bit_done,
		output presence
	);

endinterface

//--- source/ow_pkg.sv
package ow_pkg;

	// the 2-bit command code is shared by the byte and bit levels
	// at bit level reset means one reset and presence sequence
	typedef enum logic [1:0]
	{
		OW_CMD_NONE  = 2'd0,
		OW_CMD_RESET = 2'd1,
		OW_CMD_READ  = 2'd2,
		OW_CMD_WRITE = 2'd3
	} ow_cmd_t;

	typedef logic [7:0] ow_byte_t;

	// clock rate in MHz
	// kept at 1 so one microsecond is one clock
	localparam int CLKS_PER_US = 1;

	// reset sequence, normal speed, counted from the falling edge
	localparam int RESET_LEN_US = 480;
	localparam int PRESENCE_SAMPLE_US = 540;
	localparam int RESET_END_US = 960;

	// read and write time slots
	localparam int RW_INIT_US = 3;
	localparam int RW_SAMPLE_US = 15;
	localparam int RW_SLOT_US = 60;

	// bus high between two sequences
	localparam int RECOVERY_US = 2;

	// x^8 + x^5 + x^4 + 1 in reflected form
	localparam ow_byte_t CRC8_POLY = 8'h8C;

endpackage
